// ==== tests/hart_stim.txt ====
// gap op rd rs1 rs2 csr pc, then expected rd rd_value redirect redirect_pc (all hex)
// gap = idle cycles before the op; op 0 ADD, 1 SUB, 2 CSRRW, 3 CSRRS, 4 ECALL, 5 MRET
// Reset values
0 3 01 00 00 300 00000000 01 00001800 0 00000000
0 3 02 00 00 305 00000000 02 80000000 0 00000000
// Arithmetic with wrap-around
0 0 03 02 02 000 00000000 03 00000000 0 00000000
0 1 04 03 01 000 00000000 04 ffffe800 0 00000000
0 0 05 04 02 000 00000000 05 7fffe800 0 00000000
0 2 06 05 00 341 00000000 06 00000000 0 00000000
0 2 07 01 00 341 00000000 07 7fffe800 0 00000000
0 1 08 07 04 000 00000000 08 80000000 0 00000000
// x0
1 0 00 07 01 000 00000000 00 00000000 0 00000000
0 0 09 00 01 000 00000000 09 00001800 0 00000000
// CSR set and unknown address
0 3 0a 05 00 342 00000000 0a 00000000 0 00000000
0 3 0b 01 00 342 00000000 0b 7fffe800 0 00000000
0 3 0c 00 00 342 00000000 0c 7ffff800 0 00000000
0 2 0d 01 00 7c0 00000000 0d 00000000 0 00000000
0 3 0e 00 00 7c0 00000000 0e 00000000 0 00000000
// ECALL with MIE clear, then MIE set and an unaligned mtvec
2 4 00 00 00 000 00000008 00 00000000 1 80000000
0 3 0f 00 00 341 00000000 0f 00000008 0 00000000
0 3 10 00 00 342 00000000 10 0000000b 0 00000000
0 0 11 02 10 000 00000000 11 8000000b 0 00000000
0 2 12 11 00 305 00000000 12 80000000 0 00000000
0 3 13 0f 00 300 00000000 13 00001800 0 00000000
0 4 00 00 00 000 00000124 00 00000000 1 80000008
0 3 14 00 00 300 00000000 14 00001880 0 00000000
0 3 15 00 00 341 00000000 15 00000124 0 00000000
// MRET
1 5 00 00 00 000 80000010 00 00000000 1 00000124
0 3 16 00 00 300 00000000 16 00001888 0 00000000
0 3 17 00 00 342 00000000 17 0000000b 0 00000000
0 3 18 00 00 305 00000000 18 8000000b 0 00000000

// ==== hart_state.f ====
+incdir+include
hw/hart_pkg.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/retire_unit.sv
hw/hart_state.sv
tests/hart_state_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f hart_state.f --top-module hart_state_tb -o vsim

./obj_dir/vsim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    exit 1
fi

// ==== tests/hart_state_tb.sv ====
`include "hart_consts.svh"

module hart_state_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_OPS = 64;
    localparam int NCOL    = 11;   // Columns per stim line

    logic                  clk;
    logic                  arst_n;
    logic                  op_valid;
    hart_pkg::hart_op_t    op;
    logic                  done;
    hart_pkg::retire_t     retire;
    logic [`HART_XLEN-1:0] mtvec;
    logic [`HART_XLEN-1:0] mepc;

    logic [31:0] stim [0:MAX_OPS*NCOL-1];
    int          n_ops;
    int          n_idle;
    bit          loaded;

    // Expected register and CSR state, built from the stim lines
    logic [31:0] gpr_model [0:31];
    logic [31:0] exp_mtvec;
    logic [31:0] exp_mepc;

    hart_state DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_valid (op_valid),
        .op       (op),
        .done     (done),
        .retire   (retire),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and driving
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Applies stim line idx to the expected mtvec, mepc and registers
    task automatic track_csrs(input int idx);
        int                           b;
        logic [31:0]                  src;
        logic [`HART_CSR_ADDR_W-1:0]  csr;
        b   = idx * NCOL;
        src = gpr_model[stim[b+3][`HART_REG_ADDR_W-1:0]];
        csr = stim[b+5][`HART_CSR_ADDR_W-1:0];
        if (stim[b+1] == 32'd3) begin   // CSRRS, x0 as source sets no bits
            src = (csr == `HART_CSR_MTVEC) ? (exp_mtvec | src) : (exp_mepc | src);
        end
        if (stim[b+1] == 32'd2 || stim[b+1] == 32'd3) begin
            if (csr == `HART_CSR_MTVEC) begin
                exp_mtvec = src;
            end
            if (csr == `HART_CSR_MEPC) begin
                exp_mepc = src;
            end
        end else if (stim[b+1] == 32'd4) begin
            exp_mepc = stim[b+6];   // ECALL pc
        end
        if (stim[b+7][`HART_REG_ADDR_W-1:0] != '0) begin
            gpr_model[stim[b+7][`HART_REG_ADDR_W-1:0]] = stim[b+8];
        end
    endtask

    // Retirement of stim line idx, or an idle cycle when idx < 0
    task automatic check_cycle(input int idx);
        int b;
        if (idx < 0) begin
            check_value("done", 32'(done), 32'h0);
        end else begin
            b = idx * NCOL;
            check_value("done", 32'(done), 32'h1);
            check_value("retire.rd", 32'(retire.rd), stim[b+7]);
            check_value("retire.rd_value", retire.rd_value, stim[b+8]);
            check_value("retire.redirect", 32'(retire.redirect), stim[b+9]);
            check_value("retire.redirect_pc", retire.redirect_pc, stim[b+10]);
            track_csrs(idx);
        end
        check_value("mtvec", mtvec, exp_mtvec);
        check_value("mepc", mepc, exp_mepc);
    endtask

    task automatic drive_op(input int idx);
        int b;
        b           = idx * NCOL;
        op_valid    = 1'b1;
        op.op       = hart_pkg::op_e'(stim[b+1][2:0]);
        op.rd       = stim[b+2][`HART_REG_ADDR_W-1:0];
        op.rs1      = stim[b+3][`HART_REG_ADDR_W-1:0];
        op.rs2      = stim[b+4][`HART_REG_ADDR_W-1:0];
        op.csr_addr = stim[b+5][`HART_CSR_ADDR_W-1:0];
        op.pc       = stim[b+6];
    endtask

    initial begin
        int prev;
        clk       = 1'b0;
        arst_n    = 1'b0;
        op_valid  = 1'b0;
        op        = '0;
        loaded    = 1'b0;
        n_ops     = 0;
        n_idle    = 0;
        prev      = -1;
        exp_mtvec = 32'h8000_0000;
        exp_mepc  = 32'h0;
        for (int k = 0; k < 32; k++) begin
            gpr_model[k] = '0;
        end
        for (int k = 0; k < MAX_OPS * NCOL; k++) begin
            stim[k] = {16'heeee, 16'(k)};   // No valid opcode past the last line
        end
        $readmemh("tests/hart_stim.txt", stim);
        while (n_ops < MAX_OPS && stim[n_ops*NCOL+1] <= 32'd5) begin
            n_idle += int'(stim[n_ops*NCOL]);
            n_ops++;
        end
        if (n_ops == 0) begin
            $display("No operations found in tests/hart_stim.txt");
            $display("Result: FAILED");
            $fatal(1, "empty stimulus");
        end
        loaded = 1'b1;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < n_ops; i++) begin
            for (int g = 0; g < int'(stim[i*NCOL]); g++) begin
                @(negedge clk);
                check_cycle(prev);
                op_valid = 1'b0;
                prev     = -1;
            end
            @(negedge clk);
            check_cycle(prev);   // Result of the previous strobe
            drive_op(i);
            prev = i;
        end
        @(negedge clk);
        check_cycle(prev);
        op_valid = 1'b0;
        @(negedge clk);
        check_cycle(-1);
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        #((n_ops + n_idle + 20) * 100);
        $display("Timeout: the operations did not all retire in time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== hw/hart_state.sv ====
`include "hart_consts.svh"

module hart_state (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  op_valid,
    input  hart_pkg::hart_op_t    op,
    output logic                  done,
    output hart_pkg::retire_t     retire,
    output logic [`HART_XLEN-1:0] mtvec,
    output logic [`HART_XLEN-1:0] mepc
);

    logic [`HART_REG_ADDR_W-1:0] raddr1;
    logic [`HART_REG_ADDR_W-1:0] raddr2;
    logic [`HART_XLEN-1:0]       rs1_data;
    logic [`HART_XLEN-1:0]       rs2_data;
    logic [`HART_XLEN-1:0]       csr_rdata;
    hart_pkg::gpr_wr_t           gpr_wr;
    hart_pkg::csr_req_t          csr_req;
    hart_pkg::trap_ctl_t         trap;

    gpr_file u_gpr (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wr     (gpr_wr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    csr_file u_csr (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (csr_req),
        .trap    (trap),
        .rdata   (csr_rdata),
        .mtvec   (mtvec),
        .mepc    (mepc),
        .mstatus ()   // Read only through the CSR port
    );

    retire_unit u_retire (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op        (op),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .gpr_wr    (gpr_wr),
        .csr_req   (csr_req),
        .trap      (trap),
        .csr_rdata (csr_rdata),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .done      (done),
        .retire    (retire)
    );

endmodule

// ==== hw/retire_unit.sv ====
`include "hart_consts.svh"

module retire_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        op_valid,
    input  hart_pkg::hart_op_t          op,
    input  logic [`HART_XLEN-1:0]       rs1_data,
    input  logic [`HART_XLEN-1:0]       rs2_data,
    output logic [`HART_REG_ADDR_W-1:0] raddr1,
    output logic [`HART_REG_ADDR_W-1:0] raddr2,
    output hart_pkg::gpr_wr_t           gpr_wr,
    output hart_pkg::csr_req_t          csr_req,
    output hart_pkg::trap_ctl_t         trap,
    input  logic [`HART_XLEN-1:0]       csr_rdata,
    input  logic [`HART_XLEN-1:0]       mtvec,
    input  logic [`HART_XLEN-1:0]       mepc,
    output logic                        done,
    output hart_pkg::retire_t           retire
);

    logic                  wr_rd;
    logic [`HART_XLEN-1:0] rd_data;
    logic                  redirect;
    logic [`HART_XLEN-1:0] redirect_pc;
    hart_pkg::retire_t     retire_d;

    assign raddr1 = op.rs1;
    assign raddr2 = op.rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        wr_rd         = 1'b0;
        rd_data       = '0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        csr_req.we    = 1'b0;
        csr_req.addr  = op.csr_addr;
        csr_req.wdata = rs1_data;
        trap.enter    = 1'b0;
        trap.leave    = 1'b0;
        trap.epc      = op.pc;
        trap.cause    = `HART_CAUSE_ECALL_M;
        if (op_valid) begin
            case (op.op)
                hart_pkg::OP_ADD: begin
                    wr_rd   = 1'b1;
                    rd_data = rs1_data + rs2_data;
                end
                hart_pkg::OP_SUB: begin
                    wr_rd   = 1'b1;
                    rd_data = rs1_data - rs2_data;
                end
                hart_pkg::OP_CSRRW: begin
                    wr_rd      = 1'b1;
                    rd_data    = csr_rdata;   // Old value
                    csr_req.we = 1'b1;
                end
                hart_pkg::OP_CSRRS: begin
                    wr_rd         = 1'b1;
                    rd_data       = csr_rdata;
                    csr_req.we    = (op.rs1 != '0);   // rs1 = x0 is a pure read
                    csr_req.wdata = csr_rdata | rs1_data;
                end
                hart_pkg::OP_ECALL: begin
                    trap.enter  = 1'b1;
                    redirect    = 1'b1;
                    redirect_pc = {mtvec[`HART_XLEN-1:2], 2'b00};
                end
                hart_pkg::OP_MRET: begin
                    trap.leave  = 1'b1;
                    redirect    = 1'b1;
                    redirect_pc = mepc;
                end
                default: ;
            endcase
        end
    end

    assign gpr_wr.en   = wr_rd;
    assign gpr_wr.addr = op.rd;
    assign gpr_wr.data = rd_data;

    assign retire_d.rd          = wr_rd ? op.rd : '0;
    assign retire_d.rd_value    = (wr_rd && op.rd != '0) ? rd_data : '0;
    assign retire_d.redirect    = redirect;
    assign retire_d.redirect_pc = redirect_pc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retirement report, one cycle later
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            retire <= retire_d;
        end
    end

    a_retire_known: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> !$isunknown(retire))
        else $error("retire_unit report unknown while done is high");

endmodule

// ==== hw/csr_file.sv ====
`include "hart_consts.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  hart_pkg::csr_req_t    req,
    input  hart_pkg::trap_ctl_t   trap,
    output logic [`HART_XLEN-1:0] rdata,
    output logic [`HART_XLEN-1:0] mtvec,
    output logic [`HART_XLEN-1:0] mepc,
    output logic [`HART_XLEN-1:0] mstatus
);

    logic [`HART_XLEN-1:0] mcause;

    // Unknown addresses read as zero
    always_comb begin
        case (req.addr)
            `HART_CSR_MSTATUS: rdata = mstatus;
            `HART_CSR_MTVEC:   rdata = mtvec;
            `HART_CSR_MEPC:    rdata = mepc;
            `HART_CSR_MCAUSE:  rdata = mcause;
            default:           rdata = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register update, trap actions first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus <= `HART_MSTATUS_RESET;
            mtvec   <= `HART_MTVEC_RESET;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap.enter) begin
            mepc                        <= trap.epc;
            mcause                      <= trap.cause;
            mstatus[`HART_MPIE_BIT]     <= mstatus[`HART_MIE_BIT];
            mstatus[`HART_MIE_BIT]      <= 1'b0;   // Interrupts off in handler
            mstatus[`HART_MPP_LSB +: 2] <= 2'b11;
        end else if (trap.leave) begin
            mstatus[`HART_MIE_BIT]  <= mstatus[`HART_MPIE_BIT];
            mstatus[`HART_MPIE_BIT] <= 1'b1;
        end else if (req.we) begin
            case (req.addr)
                `HART_CSR_MSTATUS: mstatus <= req.wdata;
                `HART_CSR_MTVEC:   mtvec   <= req.wdata;
                `HART_CSR_MEPC:    mepc    <= req.wdata;
                `HART_CSR_MCAUSE:  mcause  <= req.wdata;
                default: ;   // Write dropped
            endcase
        end
    end

    a_trap_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        !(trap.enter && trap.leave))
        else $error("csr_file trap entry and return in the same cycle");

endmodule

// ==== hw/gpr_file.sv ====
`include "hart_consts.svh"

module gpr_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [`HART_REG_ADDR_W-1:0] raddr1,
    input  logic [`HART_REG_ADDR_W-1:0] raddr2,
    input  hart_pkg::gpr_wr_t           wr,
    output logic [`HART_XLEN-1:0]       rdata1,
    output logic [`HART_XLEN-1:0]       rdata2
);

    // x1..x31 only, x0 has no storage
    logic [`HART_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Combinational reads
    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        if (raddr1 != '0) begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 != '0) begin
            rdata2 = regs[raddr2];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
        wr.en |-> !$isunknown(wr.addr))
        else $error("gpr_file write with unknown address");

endmodule

// ==== hw/hart_pkg.sv ====
`include "hart_consts.svh"

package hart_pkg;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_CSRRW = 3'd2,
        OP_CSRRS = 3'd3,
        OP_ECALL = 3'd4,
        OP_MRET  = 3'd5
    } op_e;

    // Decoded operation as it arrives with the strobe
    typedef struct packed {
        op_e                         op;
        logic [`HART_REG_ADDR_W-1:0] rd;
        logic [`HART_REG_ADDR_W-1:0] rs1;
        logic [`HART_REG_ADDR_W-1:0] rs2;
        logic [`HART_CSR_ADDR_W-1:0] csr_addr;
        logic [`HART_XLEN-1:0]       pc;
    } hart_op_t;

    typedef struct packed {
        logic                        en;
        logic [`HART_REG_ADDR_W-1:0] addr;
        logic [`HART_XLEN-1:0]       data;
    } gpr_wr_t;

    typedef struct packed {
        logic                        we;
        logic [`HART_CSR_ADDR_W-1:0] addr;   // Also the read address
        logic [`HART_XLEN-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic                  enter;   // ECALL
        logic                  leave;   // MRET
        logic [`HART_XLEN-1:0] epc;
        logic [`HART_XLEN-1:0] cause;
    } trap_ctl_t;

    typedef struct packed {
        logic [`HART_REG_ADDR_W-1:0] rd;
        logic [`HART_XLEN-1:0]       rd_value;
        logic                        redirect;
        logic [`HART_XLEN-1:0]       redirect_pc;
    } retire_t;

endpackage

// ==== include/hart_consts.svh ====
`ifndef HART_CONSTS_SVH
`define HART_CONSTS_SVH

`define HART_XLEN          32
`define HART_REG_ADDR_W    5
`define HART_CSR_ADDR_W    12

// Machine CSR addresses
`define HART_CSR_MSTATUS   12'h300
`define HART_CSR_MTVEC     12'h305
`define HART_CSR_MEPC      12'h341
`define HART_CSR_MCAUSE    12'h342

`define HART_MSTATUS_RESET 32'h0000_1800   // MPP = machine
`define HART_MTVEC_RESET   32'h8000_0000

`define HART_CAUSE_ECALL_M 11

// mstatus bit positions
`define HART_MIE_BIT       3
`define HART_MPIE_BIT      7
`define HART_MPP_LSB       11

`endif
